// ==== source/hsi_format_pkg.sv ====
package hsi_format_pkg;

    // Geometry of one HSI sample word
    localparam int band_width   = 16;                       // Bits per signed band
    localparam int band_count   = 3;                        // Bands per vector at most
    localparam int vector_width = band_width * band_count;  // Packed vector, 48 bits

    // One signed band
    typedef logic signed [band_width-1:0] band_t;

    // The same 48-bit word read in two ways
    //   bands  : band k sits at bits k*band_width upward
    //   scalar : dot result in the low band, zero above it
    typedef union packed {
        band_t [band_count-1:0] bands;                     // Per-band view, cross results
        struct packed {
            logic [vector_width-band_width-1:0] upper;     // Unused bands of a dot result
            band_t                              dot;       // Truncated dot product
        } scalar;                                          // Scalar view, dot results
    } hsi_word_u;

endpackage

// ==== source/hsi_ctrl_pkg.sv ====
package hsi_ctrl_pkg;

    // Operation code as it arrives on the port, any value may show up
    typedef logic [3:0] op_t;

    localparam op_t op_cross = 4'd1;  // Cross product, three bands only
    localparam op_t op_dot   = 4'd2;  // Dot product over one to three bands

    // Start check outcome, held on error_code until the next start
    typedef enum logic [3:0] {
        err_none        = 4'd0,  // Run accepted
        err_op          = 4'd1,  // Bad op, or op and band count disagree
        err_input_empty = 4'd2,  // An input queue has no vector
        err_output_full = 4'd3,  // No room for a result
        err_bands       = 4'd4   // More bands than a vector holds
    } err_t;

    // Engine FSM, every encoding used
    typedef enum logic [1:0] {
        st_idle    = 2'd0,  // Waiting for start
        st_load    = 2'd1,  // Capture heads and pop both inputs
        st_compute = 2'd2,  // Cross in one cycle, dot one band per cycle
        st_write   = 2'd3   // Push result to the output queue
    } engine_state_t;

endpackage

// ==== source/sample_fifo.sv ====
`timescale 1ns/100ps

module sample_fifo #(
    parameter int WIDTH      = 32,  // Bits per entry
    parameter int FIFO_DEPTH = 16   // Entries, power of two
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,  // Push, ignored when full
    input  logic             rd_en,  // Pop, ignored when empty
    input  logic [WIDTH-1:0] data,
    output logic [WIDTH-1:0] q,      // Head word, valid while not empty
    output logic             full,
    output logic             empty
);

    localparam int ptr_w = $clog2(FIFO_DEPTH);      // Pointers wrap on their own
    localparam int cnt_w = $clog2(FIFO_DEPTH + 1);  // Must reach FIFO_DEPTH

    logic [WIDTH-1:0] mem [FIFO_DEPTH];  // Ring storage
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [cnt_w-1:0] count;             // Occupancy
    logic             push;              // Accepted write
    logic             pop;               // Accepted read

    assign push  = wr_en && !full;
    assign pop   = rd_en && !empty;
    assign full  = (count == cnt_w'(FIFO_DEPTH));
    assign empty = (count == '0);
    assign q     = mem[rd_ptr];  // Show-ahead head

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;  // Head moves on the next edge
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Both or neither, level unchanged
            endcase
        end
    end

endmodule

// ==== source/vector_engine.sv ====
`timescale 1ns/100ps

module vector_engine (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,       // Launch a run from idle
    input  hsi_ctrl_pkg::op_t         op_code,     // Sampled with start
    input  logic [1:0]                num_bands,   // Sampled with start
    input  hsi_format_pkg::hsi_word_u in1_head,    // Head of first input queue
    input  hsi_format_pkg::hsi_word_u in2_head,    // Head of second input queue
    input  logic                      in1_empty,
    input  logic                      in2_empty,
    input  logic                      out_full,
    output logic                      in1_rd_en,   // One-cycle pop
    output logic                      in2_rd_en,   // One-cycle pop
    output logic                      out_wr_en,   // One-cycle push
    output hsi_format_pkg::hsi_word_u out_data,
    output hsi_ctrl_pkg::err_t        error_code   // Held until next start
);

    import hsi_format_pkg::*;
    import hsi_ctrl_pkg::*;

    engine_state_t state;
    engine_state_t state_next;
    err_t          start_err;     // Outcome of the start checks
    logic          op_ok;         // Op and band count agree
    logic          inputs_ready;  // A pair is waiting
    logic          compute_done;  // Last compute cycle
    op_t           run_op;        // Latched for the run
    logic [1:0]    run_bands;     // Latched for the run
    logic [1:0]    band_idx;      // Dot band in progress
    hsi_word_u     vec_a;         // Captured operand from queue 1
    hsi_word_u     vec_b;         // Captured operand from queue 2
    hsi_word_u     result;        // Result being built

    assign inputs_ready = !in1_empty && !in2_empty;
    assign op_ok        = ((op_code == op_cross) && (num_bands == 2'd3)) ||
                          ((op_code == op_dot) && (num_bands != 2'd0));

    // Checks in fixed priority: bands, op, inputs, output
    always_comb begin
        if (num_bands > band_count) begin
            start_err = err_bands;
        end else if (!op_ok) begin
            start_err = err_op;
        end else if (!inputs_ready) begin
            start_err = err_input_empty;
        end else if (out_full) begin
            start_err = err_output_full;
        end else begin
            start_err = err_none;
        end
    end

    // Cross is single cycle, dot walks run_bands bands
    assign compute_done = (run_op == op_cross) || (band_idx == run_bands - 2'd1);

    // Pop only if the last write left room, else the pair stays queued
    assign in1_rd_en = (state == st_load) && !out_full;
    assign in2_rd_en = (state == st_load) && !out_full;
    assign out_wr_en = (state == st_write);
    assign out_data  = result;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (start && (start_err == err_none)) begin
                    state_next = st_load;
                end
            end
            st_load: begin
                state_next = out_full ? st_idle : st_compute;  // Full output ends run quietly
            end
            st_compute: begin
                if (compute_done) begin
                    state_next = st_write;
                end
            end
            st_write: begin
                state_next = (inputs_ready && !out_full) ? st_load : st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= st_idle;
            error_code <= err_none;
            run_op     <= '0;
            run_bands  <= '0;
            band_idx   <= '0;
        end else begin
            state <= state_next;
            if ((state == st_idle) && start) begin
                error_code <= start_err;  // Cleared on a good start
                if (start_err == err_none) begin
                    run_op    <= op_code;
                    run_bands <= num_bands;
                end
            end
            if (state == st_compute) begin
                band_idx <= band_idx + 1'b1;
            end else begin
                band_idx <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_load: begin
                vec_a  <= in1_head;
                vec_b  <= in2_head;
                result <= '0;  // Dot accumulator and upper bands start at zero
            end
            st_compute: begin
                if (run_op == op_cross) begin
                    // Each band truncated to band_width
                    result.bands[0] <= vec_a.bands[1] * vec_b.bands[2] -
                                       vec_a.bands[2] * vec_b.bands[1];
                    result.bands[1] <= vec_a.bands[2] * vec_b.bands[0] -
                                       vec_a.bands[0] * vec_b.bands[2];
                    result.bands[2] <= vec_a.bands[0] * vec_b.bands[1] -
                                       vec_a.bands[1] * vec_b.bands[0];
                end else begin
                    result.scalar.dot <= result.scalar.dot +
                                         vec_a.bands[band_idx] * vec_b.bands[band_idx];
                end
            end
            default: begin
                result <= result;  // Hold for the write cycle
            end
        endcase
    end

endmodule

// ==== source/hsi_vector_core.sv ====
`timescale 1ns/100ps

module hsi_vector_core #(
    parameter int FIFO_DEPTH = 16  // Entries per queue, power of two
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   in1_wr_en,   // Producer push, queue 1
    input  logic [hsi_format_pkg::vector_width-1:0] in1_data,
    output logic                                   in1_full,
    input  logic                                   in2_wr_en,   // Producer push, queue 2
    input  logic [hsi_format_pkg::vector_width-1:0] in2_data,
    output logic                                   in2_full,
    input  logic                                   out_rd_en,   // Consumer pop
    output logic [hsi_format_pkg::vector_width-1:0] out_data,    // Head result
    output logic                                   out_empty,
    output logic                                   out_full,
    input  logic                                   start,
    input  logic [3:0]                             op_code,
    input  logic [1:0]                             num_bands,
    output logic [3:0]                             error_code
);

    import hsi_format_pkg::*;

    logic [vector_width-1:0] in1_head;     // Show-ahead heads to engine
    logic [vector_width-1:0] in2_head;
    logic [vector_width-1:0] result_word;  // Engine result into output queue
    logic                    in1_empty;
    logic                    in2_empty;
    logic                    in1_rd_en;
    logic                    in2_rd_en;
    logic                    out_wr_en;

    // Producer side queues
    sample_fifo #(.WIDTH(vector_width), .FIFO_DEPTH(FIFO_DEPTH)) fifo_in1 (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (in1_wr_en),
        .rd_en (in1_rd_en),
        .data  (in1_data),
        .q     (in1_head),
        .full  (in1_full),
        .empty (in1_empty)
    );

    sample_fifo #(.WIDTH(vector_width), .FIFO_DEPTH(FIFO_DEPTH)) fifo_in2 (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (in2_wr_en),
        .rd_en (in2_rd_en),
        .data  (in2_data),
        .q     (in2_head),
        .full  (in2_full),
        .empty (in2_empty)
    );

    // Consumer side queue
    sample_fifo #(.WIDTH(vector_width), .FIFO_DEPTH(FIFO_DEPTH)) fifo_out (
        .clk   (clk),
        .rst_n (rst_n),
        .wr_en (out_wr_en),
        .rd_en (out_rd_en),
        .data  (result_word),
        .q     (out_data),
        .full  (out_full),
        .empty (out_empty)
    );

    vector_engine u_engine (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .op_code    (op_code),
        .num_bands  (num_bands),
        .in1_head   (in1_head),
        .in2_head   (in2_head),
        .in1_empty  (in1_empty),
        .in2_empty  (in2_empty),
        .out_full   (out_full),   // Also gates the next pop
        .in1_rd_en  (in1_rd_en),
        .in2_rd_en  (in2_rd_en),
        .out_wr_en  (out_wr_en),
        .out_data   (result_word),
        .error_code (error_code)
    );

endmodule

// ==== verification/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen #(
    parameter int HALF_PERIOD  = 50,  // 100 ns clock
    parameter int RESET_CYCLES = 10   // Cycles with rst_n low
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);  // Release away from the active edge
        rst_n = 1'b1;
    end

endmodule

// ==== verification/tb_hsi_vector_core.sv ====
`timescale 1ns/100ps

module tb_hsi_vector_core;

    import hsi_format_pkg::*;
    import hsi_ctrl_pkg::*;

    localparam int fifo_depth  = 16;
    localparam int total_pairs = 8 + 3 * 6 + fifo_depth + 4;  // Pairs over cross, dot and back-pressure
    localparam int cycle_limit = total_pairs * 8 + 200;

    logic                    clk;
    logic                    rst_n;
    logic                    in1_wr_en;
    logic                    in2_wr_en;
    logic                    out_rd_en;
    logic                    start;
    logic [vector_width-1:0] in1_data;
    logic [vector_width-1:0] in2_data;
    logic [vector_width-1:0] out_data;
    logic                    in1_full;
    logic                    in2_full;
    logic                    out_empty;
    logic                    out_full;
    logic [3:0]              op_code;
    logic [1:0]              num_bands;
    logic [3:0]              error_code;

    logic [vector_width-1:0] exp_q [$];   // Expected results in output order
    logic [vector_width-1:0] vec_a;
    logic [vector_width-1:0] vec_b;
    logic [31:0]             lcg_state;
    string                   test_name;
    int                      error_count = 0;
    int                      check_count = 0;
    int                      results_read = 0;  // Words popped from the output queue
    int                      cycle_count = 0;

    clock_gen u_clock (.clk(clk), .rst_n(rst_n));

    hsi_vector_core #(.FIFO_DEPTH(fifo_depth)) DUT (
        .clk(clk), .rst_n(rst_n),
        .in1_wr_en(in1_wr_en), .in1_data(in1_data), .in1_full(in1_full),
        .in2_wr_en(in2_wr_en), .in2_data(in2_data), .in2_full(in2_full),
        .out_rd_en(out_rd_en), .out_data(out_data),
        .out_empty(out_empty), .out_full(out_full),
        .start(start), .op_code(op_code), .num_bands(num_bands),
        .error_code(error_code)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [vector_width-1:0] rand_vector();
        logic [vector_width-1:0] v;
        logic [31:0]             w;
        for (int k = 0; k < band_count; k++) begin
            w = next_rand();
            v[k*band_width +: band_width] = w[31:16];  // Upper LCG bits
        end
        return v;
    endfunction

    // Expected word with bands truncated to band_width and unused bands zero
    function automatic logic [vector_width-1:0] ref_result(input logic [3:0] op,
            input logic [1:0] nb, input logic [vector_width-1:0] a,
            input logic [vector_width-1:0] b);
        int                      av [band_count];
        int                      bv [band_count];
        int                      acc;
        logic [vector_width-1:0] r;
        r = '0;
        for (int k = 0; k < band_count; k++) begin
            av[k] = int'(band_t'(a[k*band_width +: band_width]));
            bv[k] = int'(band_t'(b[k*band_width +: band_width]));
        end
        if (op == op_cross) begin
            r[15:0]  = band_t'(av[1] * bv[2] - av[2] * bv[1]);
            r[31:16] = band_t'(av[2] * bv[0] - av[0] * bv[2]);
            r[47:32] = band_t'(av[0] * bv[1] - av[1] * bv[0]);
        end else begin
            acc = 0;
            for (int k = 0; k < int'(nb); k++) begin
                acc = acc + av[k] * bv[k];  // Wraps in 32 bits and only the low band is kept
            end
            r[15:0] = band_t'(acc);
        end
        return r;
    endfunction

    task automatic flag_error(input string msg);
        $display("error in %s: %s", test_name, msg);
        error_count++;
    endtask

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (expected !== actual) begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    // Called on a falling edge and pushes one pair per cycle
    task automatic push_pair(input logic [vector_width-1:0] a,
                             input logic [vector_width-1:0] b,
                             input logic [3:0] op, input logic [1:0] nb);
        while (in1_full || in2_full) @(negedge clk);
        in1_data  = a;
        in2_data  = b;
        in1_wr_en = 1'b1;
        in2_wr_en = 1'b1;
        exp_q.push_back(ref_result(op, nb, a, b));
        @(negedge clk);
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
    endtask

    task automatic start_run(input logic [3:0] op, input logic [1:0] nb);
        op_code   = op;
        num_bands = nb;
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic read_results(input int n);
        int target;
        target = results_read + n;
        while (results_read < target) begin
            @(negedge clk);
            out_rd_en = !out_empty && (results_read < target);
        end
        out_rd_en = 1'b0;
    endtask

    task automatic expect_drained();
        if (exp_q.size() != 0) begin
            flag_error($sformatf("%0d results missing at end of run", exp_q.size()));
        end
        if (!out_empty) begin
            flag_error("output queue holds an unexpected result");
        end
    endtask

    task automatic check_rejected(input string name, input logic [3:0] op,
                                  input logic [1:0] nb, input err_t expected);
        start_run(op, nb);
        @(negedge clk);  // Two cycles after start
        check_value(name, 64'(expected), 64'(error_code));
        repeat (4) @(negedge clk);
        if (!out_empty) begin
            flag_error("rejected start wrote to the output queue");
        end
    endtask

    // Compare on every accepted pop with inputs settled since the falling edge
    always @(posedge clk) begin
        if (rst_n && out_rd_en && !out_empty) begin
            if (exp_q.size() == 0) begin
                flag_error("output queue delivered a result nobody expected");
            end else begin
                check_value(test_name, 64'(exp_q.pop_front()), 64'(out_data));
            end
            results_read++;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        in1_wr_en = 1'b0;
        in2_wr_en = 1'b0;
        out_rd_en = 1'b0;
        start     = 1'b0;
        in1_data  = '0;
        in2_data  = '0;
        op_code   = '0;
        num_bands = '0;
        lcg_state = 32'hc3a5_316b;
        @(posedge rst_n);
        @(negedge clk);

        test_name = "reset";
        check_value("reset out_empty", 64'(1), 64'(out_empty));
        check_value("reset in1_full", 64'(0), 64'(in1_full));
        check_value("reset in2_full", 64'(0), 64'(in2_full));
        check_value("reset out_full", 64'(0), 64'(out_full));
        check_value("reset error_code", 64'(err_none), 64'(error_code));

        test_name = "cross";
        for (int i = 0; i < 8; i++) begin
            vec_a = rand_vector();
            vec_b = rand_vector();
            push_pair(vec_a, vec_b, op_cross, 2'd3);
        end
        start_run(op_cross, 2'd3);
        @(negedge clk);
        check_value("cross error_code", 64'(err_none), 64'(error_code));
        read_results(8);
        expect_drained();

        for (int nb = 1; nb <= band_count; nb++) begin
            test_name = $sformatf("dot%0d", nb);
            for (int i = 0; i < 4; i++) begin
                vec_a = rand_vector();
                vec_b = rand_vector();
                push_pair(vec_a, vec_b, op_dot, 2'(nb));
            end
            push_pair(48'h8000_8000_8000, 48'h8000_7fff_8000, op_dot, 2'(nb));  // Sign extremes
            push_pair(48'h7fff_7fff_7fff, 48'hffff_8000_7fff, op_dot, 2'(nb));
            start_run(op_dot, 2'(nb));
            @(negedge clk);
            check_value({test_name, " error_code"}, 64'(err_none), 64'(error_code));
            read_results(6);
            expect_drained();
        end

        test_name = "errors";
        check_rejected("illegal op", 4'd5, 2'd3, err_op);
        check_rejected("cross with 2 bands", op_cross, 2'd2, err_op);
        check_rejected("dot with 0 bands", op_dot, 2'd0, err_op);
        check_rejected("empty inputs", op_dot, 2'd2, err_input_empty);

        test_name = "backpressure";
        for (int i = 0; i < fifo_depth + 4; i++) begin
            vec_a = rand_vector();
            vec_b = rand_vector();
            push_pair(vec_a, vec_b, op_cross, 2'd3);
            if (i == fifo_depth - 1) begin
                start_run(op_cross, 2'd3);  // Start once both inputs are full
            end
        end
        while (!out_full) @(negedge clk);
        repeat (2) @(negedge clk);  // Engine back in idle
        start_run(op_cross, 2'd3);
        @(negedge clk);
        check_value("backpressure full start", 64'(err_output_full), 64'(error_code));
        read_results(fifo_depth);
        start_run(op_cross, 2'd3);
        @(negedge clk);
        check_value("backpressure restart", 64'(err_none), 64'(error_code));
        read_results(4);
        expect_drained();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== hsi_vector_core.f ====
source/hsi_format_pkg.sv
source/hsi_ctrl_pkg.sv
source/sample_fifo.sv
source/vector_engine.sv
source/hsi_vector_core.sv
verification/clock_gen.sv
verification/tb_hsi_vector_core.sv

// ==== Makefile ====
TOP := tb_hsi_vector_core

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) \
		-f hsi_vector_core.f -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "TESTS PASSED"

clean:
	rm -rf obj_dir
